//--- tb/issue_trace.txt
// in:  vld pc0 ins0 ctl0 pc1 ins1 ctl1 sfw(stall,flush,wb_en) wba wbd byp(rdy,hit) bd00 bd01 bd10 bd11
// exp: vld pc0 pc1 rs0 rt0 rs1 rt1 slot full; a line of ff ends the trace
0 0 0 0 0 0 0 1 1 11 f0 0 0 0 0  0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 1 2 22 f0 0 0 0 0  0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 1 3 33 f0 0 0 0 0  0 0 0 0 0 0 0 0 0
3 100 00222820 400 104 00643020 400 1 4 44 f0 0 0 0 0  0 0 0 0 0 0 0 0 0
3 108 00223820 400 10c 00e34020 400 0 0 0 f0 0 0 0 0  3 100 104 11 22 33 44 0 0
0 0 0 0 0 0 0 0 0 0 f0 0 0 0 0  1 108 0 11 22 0 0 0 0
3 110 00220018 0e0 114 00004812 408 0 0 0 f1 77 0 0 0  1 10c 0 77 33 0 0 0 0
0 0 0 0 0 0 0 0 0 0 f0 0 0 0 0  1 110 0 11 22 0 0 0 0
3 118 0000000c 001 11c 00225020 400 0 0 0 f0 0 0 0 0  1 114 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 f0 0 0 0 0  1 118 0 0 0 0 0 0 0
3 120 40816000 004 124 400b6000 602 0 0 0 f0 0 0 0 0  1 11c 0 11 22 0 0 0 0
2 0 0 0 128 0080f809 500 0 0 0 f0 0 0 0 0  1 120 0 44 11 0 0 0 0
0 0 0 0 0 0 0 0 0 0 f0 0 0 0 0  1 124 0 0 0 0 0 0 0
1 12c 03e13820 400 0 0 0 0 0 0 f0 0 0 0 0  0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 70 0 0 0 0  0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 f0 0 0 0 0  3 128 12c 44 0 0 11 1 0
3 130 00222820 400 134 00222820 400 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
3 138 00222820 400 13c 00222820 400 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
3 140 00222820 400 144 00222820 400 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
3 148 00222820 400 14c 00222820 400 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
3 150 00222820 400 154 00222820 400 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
3 158 00222820 400 15c 00222820 400 0 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 4 0 0 f0 0 0 0 0  0 0 0 0 0 0 0 0 1
0 0 0 0 0 0 0 2 0 0 0 0 0 0 0  0 0 0 0 0 0 0 0 1
3 160 00220018 0e0 164 0064001a 0e0 0 0 0 f0 0 0 0 0  0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 f0 0 0 0 0  1 160 0 11 22 0 0 0 0
0 0 0 0 0 0 0 0 0 0 f0 0 0 0 0  1 164 0 33 44 0 0 0 0
ff

//--- all.f
+incdir+hdl
hdl/issue_pkg.sv
hdl/issue_queue.sv
hdl/pair_hazard_check.sv
hdl/operand_fetch.sv
hdl/issue_select.sv
hdl/issue_stage_top.sv
tb/issue_assertions.sv
tb/issue_stage_tb.sv

//--- Makefile
SIM := obj_dir/Vissue_stage_tb

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Verification passed" sim.log
	! grep -q "Verification failed" sim.log

$(SIM): all.f $(wildcard hdl/*.sv hdl/*.svh tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module issue_stage_tb -f all.f

clean:
	rm -rf obj_dir sim.log

//--- tb/issue_stage_tb.sv
`include "issue_defines.svh"

module issue_stage_tb import issue_pkg::*; ();

    // trace columns per line, see header of the trace file
    localparam int NTOK = 24;
    localparam int MAX_LINES = 64;
    localparam int RESET_LIMIT = 10;

    logic                             clk;
    logic                             reset;
    logic [1:0]                       in_valid;
    logic [1:0][`ISSUE_XLEN-1:0]      in_pc;
    logic [1:0][31:0]                 in_instr;
    issue_ctl_t [1:0]                 in_ctl;
    logic                             stall;
    logic                             flush;
    logic                             wb_en;
    reg_idx_t                         wb_addr;
    logic [`ISSUE_XLEN-1:0]           wb_data;
    logic [1:0][1:0]                  byp_ready;
    logic [1:0][1:0]                  byp_hit;
    logic [1:0][1:0][`ISSUE_XLEN-1:0] byp_data;
    logic [1:0]                       iss_valid;
    logic [1:0][`ISSUE_XLEN-1:0]      iss_pc;
    logic [1:0][31:0]                 iss_instr;
    issue_ctl_t [1:0]                 iss_ctl;
    logic [1:0][`ISSUE_XLEN-1:0]      iss_rs_val;
    logic [1:0][`ISSUE_XLEN-1:0]      iss_rt_val;
    logic                             iss_is_slot;
    reg_idx_t [1:0]                   iss_ra1;
    reg_idx_t [1:0]                   iss_ra2;
    logic                             full;

    logic [31:0] trace_mem [NTOK*MAX_LINES];
    // what decode sent, keyed by pc
    logic [31:0] instr_by_pc [logic [31:0]];
    issue_ctl_t  ctl_by_pc [logic [31:0]];

    issue_stage_top dut0 (.*);

    bind issue_stage_top issue_assertions u_assert (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_vec(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ctl(input string name, input issue_ctl_t got,
                             input issue_ctl_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // one trace line onto the inputs, called right after the rising edge
    task automatic drive_line(input int base);
        in_valid  <= trace_mem[base][1:0];
        in_pc     <= {trace_mem[base+4], trace_mem[base+1]};
        in_instr  <= {trace_mem[base+5], trace_mem[base+2]};
        in_ctl    <= {trace_mem[base+6][10:0], trace_mem[base+3][10:0]};
        stall     <= trace_mem[base+7][2];
        flush     <= trace_mem[base+7][1];
        wb_en     <= trace_mem[base+7][0];
        wb_addr   <= trace_mem[base+8][4:0];
        wb_data   <= trace_mem[base+9];
        byp_ready <= trace_mem[base+10][7:4];
        byp_hit   <= trace_mem[base+10][3:0];
        byp_data  <= {trace_mem[base+14], trace_mem[base+13],
                      trace_mem[base+12], trace_mem[base+11]};
        for (int s = 0; s < 2; s++) begin
            if (trace_mem[base][s]) begin
                instr_by_pc[trace_mem[base+1+3*s]] = trace_mem[base+2+3*s];
                ctl_by_pc[trace_mem[base+1+3*s]]   = trace_mem[base+3+3*s][10:0];
            end
        end
    endtask

    // outputs of the cycle, sampled at the falling edge
    task automatic check_line(input int base);
        instr_word_u w;
        logic [31:0] epc;
        check_vec("iss_valid", 32'(iss_valid), trace_mem[base+15]);
        check_vec("iss_is_slot", 32'(iss_is_slot), trace_mem[base+22]);
        check_vec("full", 32'(full), trace_mem[base+23]);
        for (int s = 0; s < 2; s++) begin
            epc = trace_mem[base+16+s];
            check_vec($sformatf("iss_pc[%0d]", s), iss_pc[s], epc);
            check_vec($sformatf("iss_rs_val[%0d]", s), iss_rs_val[s], trace_mem[base+18+2*s]);
            check_vec($sformatf("iss_rt_val[%0d]", s), iss_rt_val[s], trace_mem[base+19+2*s]);
            if (trace_mem[base+15][s]) begin
                // issued slot carries the word and control bits decode sent
                w = instr_by_pc[epc];
                check_vec($sformatf("iss_instr[%0d]", s), iss_instr[s], w);
                check_ctl($sformatf("iss_ctl[%0d]", s), iss_ctl[s], ctl_by_pc[epc]);
                check_idx($sformatf("iss_ra1[%0d]", s), iss_ra1[s], w.r.rs);
                check_idx($sformatf("iss_ra2[%0d]", s), iss_ra2[s], w.i.rt);
            end else begin
                check_vec($sformatf("iss_instr[%0d]", s), iss_instr[s], '0);
                check_ctl($sformatf("iss_ctl[%0d]", s), iss_ctl[s], '0);
            end
        end
    endtask

    initial begin
        int base;
        int line;
        int waited;
        logic done;
        in_valid  = '0;
        in_pc     = '0;
        in_instr  = '0;
        in_ctl    = '0;
        stall     = 1'b0;
        flush     = 1'b0;
        wb_en     = 1'b0;
        wb_addr   = '0;
        wb_data   = '0;
        byp_ready = '0;
        byp_hit   = '0;
        byp_data  = '0;
        $readmemh("tb/issue_trace.txt", trace_mem);
        waited = 0;
        while (reset !== 1'b0) begin
            @(negedge clk);
            waited++;
            if (waited > RESET_LIMIT) begin
                $display("timeout waiting for reset to be released");
                abort_run();
            end
        end
        line = 0;
        done = 1'b0;
        // an ff in the first column marks the end of the trace
        while (!done && line < MAX_LINES) begin
            base = line * NTOK;
            @(posedge clk);
            if (trace_mem[base] === 32'hff) begin
                done = 1'b1;
            end else begin
                drive_line(base);
                @(negedge clk);
                check_line(base);
                line++;
            end
        end
        if (done) begin
            $display("%0d trace lines checked", line);
            $display("Verification passed");
            $finish;
        end else begin
            $display("timeout, trace has no end marker within %0d lines", MAX_LINES);
            abort_run();
        end
    end

endmodule

//--- tb/issue_assertions.sv
module issue_assertions (
    input logic       clk,
    input logic       reset,
    input logic       stall,
    input logic       full,
    input logic [1:0] in_valid,
    input logic [1:0] iss_valid
);

    // decode has to hold off while a bank is nearly full
    no_strobe_when_full: assert property (
        @(posedge clk) disable iff (reset) full |-> (in_valid == 2'b00)
    ) else $error("in_valid strobed while full is high");

    // younger never leaves without the older
    issue_in_order: assert property (
        @(posedge clk) disable iff (reset) iss_valid[1] |-> iss_valid[0]
    ) else $error("younger slot issued without the older slot");

    // stall freezes issue
    quiet_on_stall: assert property (
        @(posedge clk) disable iff (reset) stall |-> (iss_valid == 2'b00)
    ) else $error("issue seen while stall is high");

endmodule

//--- hdl/issue_stage_top.sv
`include "issue_defines.svh"

module issue_stage_top import issue_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [1:0]                       in_valid,
    input  logic [1:0][`ISSUE_XLEN-1:0]      in_pc,
    input  logic [1:0][31:0]                 in_instr,
    input  issue_ctl_t [1:0]                 in_ctl,
    input  logic                             stall,
    input  logic                             flush,
    input  logic                             wb_en,
    input  reg_idx_t                         wb_addr,
    input  logic [`ISSUE_XLEN-1:0]           wb_data,
    input  logic [1:0][1:0]                  byp_ready,
    input  logic [1:0][1:0]                  byp_hit,
    input  logic [1:0][1:0][`ISSUE_XLEN-1:0] byp_data,
    output logic [1:0]                       iss_valid,
    output logic [1:0][`ISSUE_XLEN-1:0]      iss_pc,
    output logic [1:0][31:0]                 iss_instr,
    output issue_ctl_t [1:0]                 iss_ctl,
    output logic [1:0][`ISSUE_XLEN-1:0]      iss_rs_val,
    output logic [1:0][`ISSUE_XLEN-1:0]      iss_rt_val,
    output logic                             iss_is_slot,
    output reg_idx_t [1:0]                   iss_ra1,
    output reg_idx_t [1:0]                   iss_ra2,
    output logic                             full
);

    // candidate pair, index 0 older
    logic [1:0]                  cand_valid;
    queue_entry_t [1:0]          cand_entry;
    logic                        raw_hazard;
    logic                        struct_conflict;
    logic [1:0]                  slot_ready;
    logic [1:0][`ISSUE_XLEN-1:0] rs_val;
    logic [1:0][`ISSUE_XLEN-1:0] rt_val;
    logic [1:0]                  pop_cnt;

    issue_queue u_queue (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .stall      (stall),
        .in_valid   (in_valid),
        .in_pc      (in_pc),
        .in_instr   (in_instr),
        .in_ctl     (in_ctl),
        .pop_cnt    (pop_cnt),
        .cand_valid (cand_valid),
        .cand_entry (cand_entry),
        .full       (full)
    );

    // hazard check and operand fetch run in parallel
    pair_hazard_check u_hazard (
        .cand_valid      (cand_valid),
        .cand_entry      (cand_entry),
        .raw_hazard      (raw_hazard),
        .struct_conflict (struct_conflict)
    );

    operand_fetch u_opfetch (
        .clk        (clk),
        .reset      (reset),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .cand_entry (cand_entry),
        .byp_ready  (byp_ready),
        .byp_hit    (byp_hit),
        .byp_data   (byp_data),
        .iss_ra1    (iss_ra1),
        .iss_ra2    (iss_ra2),
        .slot_ready (slot_ready),
        .rs_val     (rs_val),
        .rt_val     (rt_val)
    );

    issue_select u_select (
        .stall           (stall),
        .cand_valid      (cand_valid),
        .cand_entry      (cand_entry),
        .slot_ready      (slot_ready),
        .rs_val          (rs_val),
        .rt_val          (rt_val),
        .raw_hazard      (raw_hazard),
        .struct_conflict (struct_conflict),
        .pop_cnt         (pop_cnt),
        .iss_valid       (iss_valid),
        .iss_pc          (iss_pc),
        .iss_instr       (iss_instr),
        .iss_ctl         (iss_ctl),
        .iss_rs_val      (iss_rs_val),
        .iss_rt_val      (iss_rt_val),
        .iss_is_slot     (iss_is_slot)
    );

endmodule

//--- hdl/issue_select.sv
`include "issue_defines.svh"

module issue_select import issue_pkg::*; (
    input  logic                        stall,
    input  logic [1:0]                  cand_valid,
    input  queue_entry_t [1:0]          cand_entry,
    input  logic [1:0]                  slot_ready,
    input  logic [1:0][`ISSUE_XLEN-1:0] rs_val,
    input  logic [1:0][`ISSUE_XLEN-1:0] rt_val,
    input  logic                        raw_hazard,
    input  logic                        struct_conflict,
    output logic [1:0]                  pop_cnt,
    output logic [1:0]                  iss_valid,
    output logic [1:0][`ISSUE_XLEN-1:0] iss_pc,
    output logic [1:0][31:0]            iss_instr,
    output issue_ctl_t [1:0]            iss_ctl,
    output logic [1:0][`ISSUE_XLEN-1:0] iss_rs_val,
    output logic [1:0][`ISSUE_XLEN-1:0] iss_rt_val,
    output logic                        iss_is_slot
);

    logic [1:0] issue_en;
    logic       old_branch;
    logic       yng_ok;

    assign old_branch = cand_entry[0].ctl.branch;
    assign yng_ok     = cand_valid[1] && slot_ready[1];

    // branch holds until its delay slot can go with it
    assign issue_en[0] = cand_valid[0] && slot_ready[0] && !stall &&
                         (!old_branch || yng_ok);

    // delay slot ignores raw, it reads pre-branch state anyway
    assign issue_en[1] = issue_en[0] && yng_ok && !struct_conflict &&
                         (!raw_hazard || old_branch);

    assign iss_is_slot = issue_en[1] && old_branch;

    // queue pops exactly what left
    always_comb begin
        case (issue_en)
            2'b11:   pop_cnt = 2'd2;
            2'b01:   pop_cnt = 2'd1;
            default: pop_cnt = 2'd0;
        endcase
    end

    // output bundle, zero where nothing issues
    always_comb begin
        iss_valid  = '0;
        iss_pc     = '0;
        iss_instr  = '0;
        iss_ctl    = '0;
        iss_rs_val = '0;
        iss_rt_val = '0;
        for (int s = 0; s < 2; s++) begin
            if (issue_en[s]) begin
                iss_valid[s]  = 1'b1;
                iss_pc[s]     = cand_entry[s].pc;
                iss_instr[s]  = cand_entry[s].instr;
                iss_ctl[s]    = cand_entry[s].ctl;
                iss_rs_val[s] = rs_val[s];
                iss_rt_val[s] = rt_val[s];
            end
        end
    end

endmodule

//--- hdl/operand_fetch.sv
`include "issue_defines.svh"

module operand_fetch import issue_pkg::*; (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             wb_en,
    input  reg_idx_t                         wb_addr,
    input  logic [`ISSUE_XLEN-1:0]           wb_data,
    input  queue_entry_t [1:0]               cand_entry,
    input  logic [1:0][1:0]                  byp_ready,
    input  logic [1:0][1:0]                  byp_hit,
    input  logic [1:0][1:0][`ISSUE_XLEN-1:0] byp_data,
    output reg_idx_t [1:0]                   iss_ra1,
    output reg_idx_t [1:0]                   iss_ra2,
    output logic [1:0]                       slot_ready,
    output logic [1:0][`ISSUE_XLEN-1:0]      rs_val,
    output logic [1:0][`ISSUE_XLEN-1:0]      rt_val
);

    logic [`ISSUE_XLEN-1:0]      regs [`ISSUE_NREGS];
    logic [1:0][`ISSUE_XLEN-1:0] rf_rs, rf_rt;

    // one write port
    // writeback lands at the edge, same-cycle read sees old value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < `ISSUE_NREGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_en && (wb_addr != '0)) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // four read ports, rs/rt per slot
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            iss_ra1[s] = cand_entry[s].instr.r.rs;
            iss_ra2[s] = cand_entry[s].instr.i.rt;
            // r0 hardwired
            if (iss_ra1[s] == '0) begin
                rf_rs[s] = '0;
            end else begin
                rf_rs[s] = regs[iss_ra1[s]];
            end
            if (iss_ra2[s] == '0) begin
                rf_rt[s] = '0;
            end else begin
                rf_rt[s] = regs[iss_ra2[s]];
            end
        end
    end

    // bypass wins on hit
    // operand 0 is rs, operand 1 is rt
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            rs_val[s]     = byp_hit[s][0] ? byp_data[s][0] : rf_rs[s];
            rt_val[s]     = byp_hit[s][1] ? byp_data[s][1] : rf_rt[s];
            slot_ready[s] = byp_ready[s][0] && byp_ready[s][1];
        end
    end

endmodule

//--- hdl/pair_hazard_check.sv
module pair_hazard_check import issue_pkg::*; (
    input  logic [1:0]         cand_valid,
    input  queue_entry_t [1:0] cand_entry,
    output logic               raw_hazard,
    output logic               struct_conflict
);

    instr_word_u old_w, yng_w;
    issue_ctl_t  old_c, yng_c;
    reg_idx_t    old_dst;
    logic        pair_valid;
    logic        muldiv_pair;
    logic        hilo_dep;
    logic        cp0_dep;

    // slot 0 older, slot 1 younger
    assign old_w = cand_entry[0].instr;
    assign yng_w = cand_entry[1].instr;
    assign old_c = cand_entry[0].ctl;
    assign yng_c = cand_entry[1].ctl;

    assign pair_valid = &cand_valid;

    // i-type writes rt, r-type writes rd
    assign old_dst = old_c.dst_is_rt ? old_w.i.rt : old_w.r.rd;

    // r0 not excluded, conservative
    assign raw_hazard = pair_valid && old_c.regwrite &&
                        ((old_dst == yng_w.r.rs) || (old_dst == yng_w.r.rt));

    // single mul/div unit
    assign muldiv_pair = old_c.muldiv && yng_c.muldiv;

    // mthi/mtlo or mult ahead of mfhi/mflo
    assign hilo_dep = (old_c.hiwrite && yng_c.hiread) ||
                      (old_c.lowrite && yng_c.loread);

    // cp0 address unknown here, so any overlap serializes
    assign cp0_dep = (old_c.cp0write && (yng_c.cp0read || yng_c.cp0write)) ||
                     (old_c.cp0read && yng_c.cp0read);

    // trap flushes younger anyway
    // branch never sits in a delay slot
    assign struct_conflict = pair_valid &&
                             (muldiv_pair || hilo_dep || cp0_dep ||
                              old_c.trap || yng_c.branch);

endmodule

//--- hdl/issue_queue.sv
`include "issue_defines.svh"

module issue_queue import issue_pkg::*; (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,
    input  logic                        stall,
    input  logic [1:0]                  in_valid,
    input  logic [1:0][`ISSUE_XLEN-1:0] in_pc,
    input  logic [1:0][31:0]            in_instr,
    input  issue_ctl_t [1:0]            in_ctl,
    input  logic [1:0]                  pop_cnt,
    output logic [1:0]                  cand_valid,
    output queue_entry_t [1:0]          cand_entry,
    output logic                        full
);

    // two circular banks, payload only
    queue_entry_t bank_even [`ISSUE_BANK_DEPTH];
    queue_entry_t bank_odd  [`ISSUE_BANK_DEPTH];

    logic [`ISSUE_PTR_W-1:0] head_even, head_odd;
    logic [`ISSUE_PTR_W-1:0] tail_even, tail_odd;
    logic [`ISSUE_PTR_W-1:0] occ_even, occ_odd;
    logic                    odd_older, odd_due;
    logic                    even_empty, odd_empty;
    queue_entry_t            first_entry, second_entry;
    logic                    first_we, second_we;
    logic                    even_we, odd_we;
    queue_entry_t            even_wdata, odd_wdata;
    logic                    pop_one, pop_two;
    logic                    adv_even, adv_odd;

    // equal pointers -> odd bank is ahead
    assign odd_older = (head_odd == head_even);
    assign odd_due   = (tail_odd == tail_even);

    assign even_empty = (head_even == tail_even);
    assign odd_empty  = (head_odd == tail_odd);

    // one spare entry per bank kept, so flag at depth-2
    assign occ_even = tail_even - head_even;
    assign occ_odd  = tail_odd - head_odd;
    assign full     = (occ_even >= (`ISSUE_BANK_DEPTH - 2)) ||
                      (occ_odd >= (`ISSUE_BANK_DEPTH - 2));

    // lone instruction may sit in either slot
    always_comb begin
        if (in_valid[0]) begin
            first_entry.instr = in_instr[0];
            first_entry.pc    = in_pc[0];
            first_entry.ctl   = in_ctl[0];
        end else begin
            first_entry.instr = in_instr[1];
            first_entry.pc    = in_pc[1];
            first_entry.ctl   = in_ctl[1];
        end
        second_entry.instr = in_instr[1];
        second_entry.pc    = in_pc[1];
        second_entry.ctl   = in_ctl[1];
    end

    assign first_we  = |in_valid;
    assign second_we = &in_valid;

    // steer to bank due next, then the other
    assign odd_we     = odd_due ? first_we : second_we;
    assign even_we    = odd_due ? second_we : first_we;
    assign odd_wdata  = odd_due ? first_entry : second_entry;
    assign even_wdata = odd_due ? second_entry : first_entry;

    // pop one -> older bank only, two -> both
    assign pop_one  = (pop_cnt != 2'd0);
    assign pop_two  = (pop_cnt == 2'd2);
    assign adv_odd  = odd_older ? pop_one : pop_two;
    assign adv_even = odd_older ? pop_two : pop_one;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head_even <= '0;
            head_odd  <= '0;
            tail_even <= '0;
            tail_odd  <= '0;
        end else if (!stall) begin
            if (even_we) begin
                tail_even <= tail_even + 1'b1;
            end
            if (odd_we) begin
                tail_odd <= tail_odd + 1'b1;
            end
            if (adv_even) begin
                head_even <= head_even + 1'b1;
            end
            if (adv_odd) begin
                head_odd <= head_odd + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (even_we) begin
                bank_even[tail_even] <= even_wdata;
            end
            if (odd_we) begin
                bank_odd[tail_odd] <= odd_wdata;
            end
        end
    end

    // candidate pair in age order, idle slots zeroed
    always_comb begin
        if (odd_older) begin
            cand_valid[0] = !odd_empty;
            cand_valid[1] = !odd_empty && !even_empty;
            cand_entry[0] = bank_odd[head_odd];
            cand_entry[1] = bank_even[head_even];
        end else begin
            cand_valid[0] = !even_empty;
            cand_valid[1] = !even_empty && !odd_empty;
            cand_entry[0] = bank_even[head_even];
            cand_entry[1] = bank_odd[head_odd];
        end
        for (int s = 0; s < 2; s++) begin
            if (!cand_valid[s]) begin
                cand_entry[s] = '0;
            end
        end
    end

endmodule

//--- hdl/issue_pkg.sv
`include "issue_defines.svh"

package issue_pkg;

    // gpr index
    typedef logic [4:0] reg_idx_t;

    // r-type view of the instruction word
    typedef struct packed {
        logic [5:0] opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    // i-type view, same rs/rt positions
    typedef struct packed {
        logic [5:0]  opcode;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
    } i_fields_t;

    // one word, two decodings
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_word_u;

    // decoded control bits from decode
    typedef struct packed {
        logic regwrite;
        // dest is rt (i-type) instead of rd
        logic dst_is_rt;
        // branch or jump
        logic branch;
        logic muldiv;
        logic hiwrite;
        logic lowrite;
        logic hiread;
        logic loread;
        logic cp0write;
        logic cp0read;
        // exception or eret
        logic trap;
    } issue_ctl_t;

    // one queue slot, 75 bits
    typedef struct packed {
        instr_word_u            instr;
        logic [`ISSUE_XLEN-1:0] pc;
        issue_ctl_t             ctl;
    } queue_entry_t;

endpackage

//--- hdl/issue_defines.svh
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// entries per bank, power of two (4, 8 or 16)
`define ISSUE_BANK_DEPTH 8

// head/tail pointer width, wraps naturally
`define ISSUE_PTR_W $clog2(`ISSUE_BANK_DEPTH)

// architectural gprs
`define ISSUE_NREGS 32

// datapath width
`define ISSUE_XLEN 32

`endif
